// File: list.f
rtl/core_pkg.sv
rtl/decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/stage_register.sv
rtl/core.sv
testbench/core_sva.sv
testbench/tb_core.sv

// File: run.sh
#!/bin/bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_core -f list.f -o tb_core_sim \
	&& ./obj_dir/tb_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: testbench/tb_core.sv
`timescale 1ns/1ps

module tb_core;

	localparam int BODY_LEN = 120;
	localparam int PROG_LEN = BODY_LEN + 32; // body plus 31 dump stores and the final loop
	localparam logic [31:0] DATA_BASE  = 32'h0000_0100;
	localparam logic [31:0] DUMP_BASE  = 32'h0000_0400;
	localparam logic [31:0] LOOP_INSTR = 32'h0000_006f; // jal x0, 0

	logic        clk_i;
	logic        reset_i;
	logic [31:0] instr_i;
	logic [31:0] instr_addr_o;
	logic [31:0] data_i = '0;
	logic [31:0] data_addr_o;
	logic [31:0] data_o;
	logic        data_req_o;
	logic        data_we_o;
	logic        data_stall_i = 1'b0;

	logic [31:0] imem [0:PROG_LEN-1];
	logic [31:0] dmem [logic [31:0]];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] rng;
	bit          targeted [0:PROG_LEN-1]; // slots that some jump lands on
	logic [31:0] loop_addr;
	logic        accept_pending = 1'b0;
	logic        accept_we;
	logic [31:0] accept_addr, accept_data;

	core i_core (.*);

	initial
	begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// untouched data words
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
	endfunction

	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		logic [31:0] idx;
		idx = (addr - core_pkg::RESET_VECTOR) >> 2;
		if (idx < PROG_LEN)
			return imem[idx];
		return core_pkg::NOP_INSTR;
	endfunction

	always_comb instr_i = fetch_word(instr_addr_o); // same-cycle fetch

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], core_pkg::OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], core_pkg::OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, core_pkg::OP_JAL};
	endfunction

	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// random body with forward control flow only and a register dump at the end
	task automatic build_program();
		int          i;
		int          s;
		logic [31:0] r;
		logic [31:0] upper;
		logic [4:0]  rd, ra, rb;
		logic [2:0]  f3;
		logic [11:0] imm;
		for (i = 0; i < PROG_LEN; i++)
			targeted[i] = 1'b0;
		i = 0;
		while (i < BODY_LEN)
		begin
			r   = next_rand();
			rd  = 5'(1 + next_rand() % 15);
			ra  = 5'(next_rand() % 16);
			rb  = 5'(next_rand() % 16);
			f3  = r[10:8];
			imm = 12'(next_rand());
			case (r % 10)
				0, 1, 2: imem[i] = enc_r({1'b0, r[11] && (f3 == 3'd0 || f3 == 3'd5), 5'b0},
					rb, ra, f3, rd, core_pkg::OP_REG);
				3, 4:
				begin
					if (f3 == 3'd1)
						imm = {7'b0, imm[4:0]};
					else if (f3 == 3'd5)
						imm = {1'b0, r[11], 5'b0, imm[4:0]};
					imem[i] = enc_i(imm, ra, f3, rd, core_pkg::OP_IMM);
				end
				5:
				begin
					upper   = next_rand();
					imem[i] = {upper[31:12], rd, r[8] ? core_pkg::OP_LUI : core_pkg::OP_AUIPC};
				end
				6:
				begin
					imm = 12'(DATA_BASE + 4 * (next_rand() % 16));
					imem[i] = enc_i(imm, 5'd0, 3'b010, rd, core_pkg::OP_LOAD);
					if (r[9] && i + 1 < BODY_LEN)
					begin
						i++; // direct user of the load
						imem[i] = enc_r(7'b0, rb, rd, 3'b000, 5'(1 + r[14:12]), core_pkg::OP_REG);
					end
				end
				7: imem[i] = enc_s(12'(DATA_BASE + 4 * (next_rand() % 16)), rb, 5'd0);
				8:
				begin
					s = int'(next_rand() % 3);
					if (i + 1 + s > BODY_LEN)
						s = BODY_LEN - 1 - i;
					if (f3 == 3'd2 || f3 == 3'd3)
						f3 ^= 3'b100;
					imem[i] = enc_b(13'(4 * (1 + s)), rb, ra, f3);
					targeted[i + 1 + s] = 1'b1;
				end
				default:
				begin
					s = int'(next_rand() % 3);
					if (r[8] && i + 2 < BODY_LEN && !targeted[i + 1])
					begin
						// auipc gives jalr a known base
						if (i + 2 + s > BODY_LEN)
							s = BODY_LEN - 2 - i;
						imem[i] = {20'b0, rd, core_pkg::OP_AUIPC};
						imem[i + 1] = enc_i(12'(8 + 4 * s + int'(r[9])), rd, 3'b000, ra,
							core_pkg::OP_JALR);
						targeted[i + 2 + s] = 1'b1;
						i++;
					end
					else
					begin
						if (i + 1 + s > BODY_LEN)
							s = BODY_LEN - 1 - i;
						imem[i] = enc_j(21'(4 * (1 + s)), ra);
						targeted[i + 1 + s] = 1'b1;
					end
				end
			endcase
			i++;
		end
		for (i = 1; i < 32; i++)
			imem[BODY_LEN + i - 1] = enc_s(12'(DUMP_BASE + 4 * (i - 1)), 5'(i), 5'd0);
		imem[PROG_LEN - 1] = LOOP_INSTR;
	endtask

	// architectural model that fills the expected store queues
	function automatic void run_reference();
		logic [31:0] regs [0:31];
		logic [31:0] rmem [logic [31:0]];
		logic [31:0] pc, nxt, ins, a, b, ea, imm_i, imm_s, imm_b, imm_j, wval;
		logic [31:0] idx;
		logic        wen, take;
		for (int k = 0; k < 32; k++)
			regs[k] = '0;
		pc = core_pkg::RESET_VECTOR;
		for (int step = 0; step < 100000; step++)
		begin
			idx = (pc - core_pkg::RESET_VECTOR) >> 2;
			if (idx >= PROG_LEN)
				break;
			ins = imem[idx];
			if (ins == LOOP_INSTR)
				break;
			a     = regs[ins[19:15]];
			b     = regs[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			nxt   = pc + 32'd4;
			wen   = 1'b1;
			wval  = '0;
			case (ins[6:0])
				core_pkg::OP_LUI:   wval = {ins[31:12], 12'b0};
				core_pkg::OP_AUIPC: wval = pc + {ins[31:12], 12'b0};
				core_pkg::OP_JAL:
				begin
					wval = pc + 32'd4;
					nxt  = pc + imm_j;
				end
				core_pkg::OP_JALR:
				begin
					wval = pc + 32'd4;
					nxt  = (a + imm_i) & ~32'd1;
				end
				core_pkg::OP_BRANCH:
				begin
					wen = 1'b0;
					case (ins[14:12])
						3'd0: take = a == b;
						3'd1: take = a != b;
						3'd4: take = $signed(a) < $signed(b);
						3'd5: take = $signed(a) >= $signed(b);
						3'd6: take = a < b;
						default: take = a >= b;
					endcase
					if (take)
						nxt = pc + imm_b;
				end
				core_pkg::OP_LOAD:
				begin
					ea   = a + imm_i;
					wval = rmem.exists(ea) ? rmem[ea] : fill_word(ea);
				end
				core_pkg::OP_STORE:
				begin
					wen = 1'b0;
					ea  = a + imm_s;
					exp_addr.push_back(ea);
					exp_data.push_back(b);
					rmem[ea] = b;
				end
				core_pkg::OP_IMM: wval = alu_model(ins[14:12], ins[30] && ins[14:12] == 3'd5,
					a, imm_i);
				default: wval = alu_model(ins[14:12], ins[30], a, b);
			endcase
			if (wen && ins[11:7] != 5'd0)
				regs[ins[11:7]] = wval;
			pc = nxt;
		end
	endfunction

	task automatic fail_run();
		$display("ERRORS FOUND");
		$fatal(1, "stopping at the first error");
	endtask

	// outputs settle mid-cycle and the next rising edge accepts
	always @(negedge clk_i)
	begin
		accept_pending = reset_i && data_req_o && !data_stall_i;
		accept_we      = data_we_o;
		accept_addr    = data_addr_o;
		accept_data    = data_o;
		if (accept_pending && accept_we)
		begin
			assert (exp_addr.size() > 0)
			else
			begin
				$display("the core stored to %h after the last expected store", data_addr_o);
				fail_run();
			end
			assert (data_addr_o == exp_addr[0])
			else
			begin
				$display("ERR data_addr_o expected %h observed %h", exp_addr[0], data_addr_o);
				fail_run();
			end
			assert (data_o == exp_data[0])
			else
			begin
				$display("ERR data_o expected %h observed %h", exp_data[0], data_o);
				fail_run();
			end
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
		end
	end

	// data memory and stall pattern
	always @(posedge clk_i)
	begin
		if (reset_i)
		begin
			data_stall_i <= (next_rand() % 4) == 0;
			if (accept_pending)
			begin
				if (accept_we)
					dmem[accept_addr] = accept_data;
				else
					data_i <= dmem.exists(accept_addr) ? dmem[accept_addr] : fill_word(accept_addr);
			end
		end
	end

	initial
	begin
		repeat (8 + PROG_LEN * 8) @(posedge clk_i);
		$display("timeout, the program never reached its final loop");
		fail_run();
	end

	initial
	begin
		reset_i = 1'b0;
		rng     = 32'hfa8d_cd3f;
		build_program();
		run_reference();
		loop_addr = core_pkg::RESET_VECTOR + 32'(4 * (PROG_LEN - 1));
		repeat (7) @(posedge clk_i);
		@(negedge clk_i);
		assert (instr_addr_o == core_pkg::RESET_VECTOR)
		else
		begin
			$display("ERR instr_addr_o expected %h observed %h", core_pkg::RESET_VECTOR,
				instr_addr_o);
			fail_run();
		end
		assert (!data_req_o)
		else
		begin
			$display("data request is active during reset");
			fail_run();
		end
		@(posedge clk_i);
		reset_i <= 1'b1;
		while (!(instr_addr_o == loop_addr && exp_addr.size() == 0))
			@(negedge clk_i);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: testbench/core_sva.sv
`timescale 1ns/1ps

module core_sva (
	input logic        clk_i,
	input logic        reset_i,
	input logic [31:0] instr_addr_o,
	input logic [31:0] data_addr_o,
	input logic [31:0] data_o,
	input logic        data_req_o,
	input logic        data_we_o,
	input logic        data_stall_i
);

	// a store is always a request
	assert property (@(posedge clk_i) disable iff (!reset_i) data_we_o |-> data_req_o)
		else $error("store enable without a request");

	// stalled request must be presented again unchanged
	assert property (@(posedge clk_i) disable iff (!reset_i)
		(data_req_o && data_stall_i) |=> (data_req_o && $stable(data_we_o) &&
		$stable(data_addr_o) && $stable(data_o)))
		else $error("request changed while stalled");

	assert property (@(posedge clk_i) disable iff (!reset_i)
		data_stall_i |=> $stable(instr_addr_o))
		else $error("fetch address moved while stalled");

	assert property (@(posedge clk_i) disable iff (!reset_i) instr_addr_o[1:0] == 2'b00)
		else $error("fetch address not word aligned");

endmodule

bind core core_sva i_core_sva (.*);

// File: rtl/core.sv
`timescale 1ns/1ps

module core (
	input  logic        clk_i,
	input  logic        reset_i,
	input  logic [31:0] instr_i,
	output logic [31:0] instr_addr_o,
	input  logic [31:0] data_i,
	output logic [31:0] data_addr_o,
	output logic [31:0] data_o,
	output logic        data_req_o,
	output logic        data_we_o,
	input  logic        data_stall_i
);

	logic [core_pkg::XLEN-1:0]       pc;
	logic [31:0]                     if_instr; // fetch/decode slot
	logic [core_pkg::XLEN-1:0]       if_pc;
	logic [core_pkg::REG_ADDR_W-1:0] id_rs1, id_rs2;
	logic [core_pkg::XLEN-1:0]       id_rs1_val, id_rs2_val;
	core_pkg::alu_op_t               dec_alu_op;
	core_pkg::wb_sel_t               dec_wb_sel;
	logic [31:0]                     dec_imm;
	logic dec_a_pc, dec_b_imm, dec_jump, dec_jalr, dec_branch, dec_load, dec_store, dec_rf_we;
	core_pkg::id_ex_t                id_ex_d, id_ex_q;
	core_pkg::ex_mem_t               ex_mem_d, ex_mem_q;
	core_pkg::mem_wb_t               mem_wb_d, mem_wb_q;
	logic [1:0]                      fwd_a, fwd_b;
	logic                            load_use_stall;
	logic [core_pkg::XLEN-1:0]       op_a, op_b, alu_a, alu_b, alu_result;
	logic [core_pkg::XLEN-1:0]       target_sum, branch_target;
	logic                            taken;
	logic [core_pkg::XLEN-1:0]       mem_value, wb_value;

	assign instr_addr_o = pc;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			pc       <= core_pkg::RESET_VECTOR;
			if_instr <= core_pkg::NOP_INSTR;
			if_pc    <= '0;
		end
		else if (!data_stall_i)
		begin
			if (taken)
			begin
				pc       <= branch_target;
				if_instr <= core_pkg::NOP_INSTR; // squash the wrong-path fetch
			end
			else if (!load_use_stall)
			begin
				pc       <= pc + core_pkg::XLEN'(4);
				if_instr <= instr_i;
				if_pc    <= pc;
			end
		end
	end

	// lui adds its immediate to x0, its rs1 field is immediate bits
	assign id_rs1 = (if_instr[6:0] == core_pkg::OP_LUI) ? '0 : if_instr[19:15];
	assign id_rs2 = if_instr[24:20];

	decoder i_decoder (
		.instr_i  (if_instr),
		.alu_op_o (dec_alu_op),
		.wb_sel_o (dec_wb_sel),
		.imm_o    (dec_imm),
		.a_pc_o   (dec_a_pc),
		.b_imm_o  (dec_b_imm),
		.jump_o   (dec_jump),
		.jalr_o   (dec_jalr),
		.branch_o (dec_branch),
		.load_o   (dec_load),
		.store_o  (dec_store),
		.rf_we_o  (dec_rf_we)
	);

	register_file i_register_file (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.rs1_i      (id_rs1),
		.rs2_i      (id_rs2),
		.rs1_data_o (id_rs1_val),
		.rs2_data_o (id_rs2_val),
		.rd_i       (mem_wb_q.rd),
		.rd_data_i  (wb_value),
		.we_i       (mem_wb_q.rf_we)
	);

	always_comb
	begin
		id_ex_d.pc      = if_pc;
		id_ex_d.rs1_val = id_rs1_val;
		id_ex_d.rs2_val = id_rs2_val;
		id_ex_d.rs1     = id_rs1;
		id_ex_d.rs2     = id_rs2;
		id_ex_d.rd      = if_instr[11:7];
		id_ex_d.imm     = dec_imm;
		id_ex_d.alu_op  = dec_alu_op;
		id_ex_d.a_pc    = dec_a_pc;
		id_ex_d.b_imm   = dec_b_imm;
		id_ex_d.jump    = dec_jump;
		id_ex_d.jalr    = dec_jalr;
		id_ex_d.branch  = dec_branch;
		id_ex_d.load    = dec_load;
		id_ex_d.store   = dec_store;
		id_ex_d.rf_we   = dec_rf_we;
		id_ex_d.wb_sel  = dec_wb_sel;
	end

	stage_register #(.payload_t(core_pkg::id_ex_t)) i_id_ex (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.hold_i   (data_stall_i),
		.bubble_i (!data_stall_i && (taken || load_use_stall)),
		.d_i      (id_ex_d),
		.q_o      (id_ex_q)
	);

	hazard_unit i_hazard_unit (
		.id_rs1_i         (id_rs1),
		.id_rs2_i         (id_rs2),
		.ex_rs1_i         (id_ex_q.rs1),
		.ex_rs2_i         (id_ex_q.rs2),
		.ex_rd_i          (id_ex_q.rd),
		.ex_load_i        (id_ex_q.load),
		.mem_rd_i         (ex_mem_q.rd),
		.mem_we_i         (ex_mem_q.rf_we),
		.wb_rd_i          (mem_wb_q.rd),
		.wb_we_i          (mem_wb_q.rf_we),
		.fwd_a_o          (fwd_a),
		.fwd_b_o          (fwd_b),
		.load_use_stall_o (load_use_stall)
	);

	assign op_a = (fwd_a == core_pkg::FWD_MEM) ? mem_value :
		(fwd_a == core_pkg::FWD_WB) ? wb_value : id_ex_q.rs1_val;
	assign op_b = (fwd_b == core_pkg::FWD_MEM) ? mem_value :
		(fwd_b == core_pkg::FWD_WB) ? wb_value : id_ex_q.rs2_val;
	assign alu_a = id_ex_q.a_pc ? id_ex_q.pc : op_a;
	assign alu_b = id_ex_q.b_imm ? id_ex_q.imm : op_b;

	alu i_alu (
		.a_i      (alu_a),
		.b_i      (alu_b),
		.op_i     (id_ex_q.alu_op),
		.result_o (alu_result)
	);

	// jalr is relative to rs1, everything else to pc
	assign target_sum    = (id_ex_q.jalr ? op_a : id_ex_q.pc) + id_ex_q.imm;
	assign branch_target = {target_sum[31:1], target_sum[0] & ~id_ex_q.jalr};
	assign taken         = id_ex_q.jump || (id_ex_q.branch && alu_result[0]);

	assign data_req_o  = id_ex_q.load || id_ex_q.store;
	assign data_we_o   = id_ex_q.store;
	assign data_addr_o = alu_result;
	assign data_o      = op_b;

	always_comb
	begin
		ex_mem_d.result = alu_result;
		ex_mem_d.pc4    = id_ex_q.pc + core_pkg::XLEN'(4);
		ex_mem_d.rd     = id_ex_q.rd;
		ex_mem_d.rf_we  = id_ex_q.rf_we;
		ex_mem_d.load   = id_ex_q.load;
		ex_mem_d.wb_sel = id_ex_q.wb_sel;
	end

	stage_register #(.payload_t(core_pkg::ex_mem_t)) i_ex_mem (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.hold_i   (data_stall_i),
		.bubble_i (1'b0),
		.d_i      (ex_mem_d),
		.q_o      (ex_mem_q)
	);

	// link value replaces the alu result for jumps
	assign mem_value = (ex_mem_q.wb_sel == core_pkg::WB_PC4) ? ex_mem_q.pc4 : ex_mem_q.result;

	always_comb
	begin
		mem_wb_d.result    = mem_value;
		mem_wb_d.load_data = ex_mem_q.load ? data_i : '0;
		mem_wb_d.rd        = ex_mem_q.rd;
		mem_wb_d.rf_we     = ex_mem_q.rf_we;
		mem_wb_d.wb_sel    = ex_mem_q.wb_sel;
	end

	stage_register #(.payload_t(core_pkg::mem_wb_t)) i_mem_wb (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.hold_i   (data_stall_i),
		.bubble_i (1'b0),
		.d_i      (mem_wb_d),
		.q_o      (mem_wb_q)
	);

	assign wb_value = (mem_wb_q.wb_sel == core_pkg::WB_LOAD) ? mem_wb_q.load_data : mem_wb_q.result;

endmodule

// File: rtl/stage_register.sv
`timescale 1ns/1ps

module stage_register #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk_i,
	input  logic     reset_i,
	input  logic     hold_i,
	input  logic     bubble_i,
	input  payload_t d_i,
	output payload_t q_o
);

	// an all-zero payload is a bubble: no write, no load, no store
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			q_o <= '0;
		else if (bubble_i)
			q_o <= '0;
		else if (!hold_i)
			q_o <= d_i;
	end

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	input  logic [core_pkg::REG_ADDR_W-1:0] id_rs1_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] id_rs2_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] ex_rs1_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] ex_rs2_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] ex_rd_i,
	input  logic                            ex_load_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] mem_rd_i,
	input  logic                            mem_we_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] wb_rd_i,
	input  logic                            wb_we_i,
	output logic [1:0]                      fwd_a_o,
	output logic [1:0]                      fwd_b_o,
	output logic                            load_use_stall_o
);

	// youngest producer wins
	function automatic logic [1:0] fwd_sel(input logic [core_pkg::REG_ADDR_W-1:0] rs);
		if (rs == '0)
			return core_pkg::FWD_RF;
		else if (mem_we_i && mem_rd_i == rs)
			return core_pkg::FWD_MEM;
		else if (wb_we_i && wb_rd_i == rs)
			return core_pkg::FWD_WB;
		else
			return core_pkg::FWD_RF;
	endfunction

	assign fwd_a_o = fwd_sel(ex_rs1_i);
	assign fwd_b_o = fwd_sel(ex_rs2_i);

	// load data only exists after the memory stage
	assign load_use_stall_o = ex_load_i && (ex_rd_i != '0) &&
		(ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [core_pkg::XLEN-1:0] a_i,
	input  logic [core_pkg::XLEN-1:0] b_i,
	input  core_pkg::alu_op_t         op_i,
	output logic [core_pkg::XLEN-1:0] result_o
);

	logic lt_s, lt_u;

	assign lt_s = $signed(a_i) < $signed(b_i);
	assign lt_u = a_i < b_i;

	always_comb
	begin
		case (op_i)
			core_pkg::ALU_ADD:  result_o = a_i + b_i;
			core_pkg::ALU_SUB:  result_o = a_i - b_i;
			core_pkg::ALU_AND:  result_o = a_i & b_i;
			core_pkg::ALU_OR:   result_o = a_i | b_i;
			core_pkg::ALU_XOR:  result_o = a_i ^ b_i;
			core_pkg::ALU_SLL:  result_o = a_i << b_i[4:0];
			core_pkg::ALU_SRL:  result_o = a_i >> b_i[4:0];
			core_pkg::ALU_SRA:  result_o = $signed(a_i) >>> b_i[4:0];
			// compares, result in bit zero
			core_pkg::ALU_SLT,
			core_pkg::ALU_LT:   result_o = {31'b0, lt_s};
			core_pkg::ALU_SLTU,
			core_pkg::ALU_LTU:  result_o = {31'b0, lt_u};
			core_pkg::ALU_GE:   result_o = {31'b0, ~lt_s};
			core_pkg::ALU_GEU:  result_o = {31'b0, ~lt_u};
			core_pkg::ALU_EQ:   result_o = {31'b0, a_i == b_i};
			default:            result_o = {31'b0, a_i != b_i}; // ne
		endcase
	end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                            clk_i,
	input  logic                            reset_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] rs1_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] rs2_i,
	output logic [core_pkg::XLEN-1:0]       rs1_data_o,
	output logic [core_pkg::XLEN-1:0]       rs2_data_o,
	input  logic [core_pkg::REG_ADDR_W-1:0] rd_i,
	input  logic [core_pkg::XLEN-1:0]       rd_data_i,
	input  logic                            we_i
);

	logic [core_pkg::XLEN-1:0] regs [1:31]; // no storage for x0

	// written mid-cycle so decode sees the value on the next rising edge
	always_ff @(negedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we_i && rd_i != '0)
			regs[rd_i] <= rd_data_i;
	end

	assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// File: rtl/decoder.sv
`timescale 1ns/1ps

module decoder (
	input  logic [31:0]       instr_i,
	output core_pkg::alu_op_t alu_op_o,
	output core_pkg::wb_sel_t wb_sel_o,
	output logic [31:0]       imm_o,
	output logic              a_pc_o,   // operand a is pc
	output logic              b_imm_o,  // operand b is immediate
	output logic              jump_o,
	output logic              jalr_o,
	output logic              branch_o,
	output logic              load_o,
	output logic              store_o,
	output logic              rf_we_o
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'b0};
	assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	always_comb
	begin
		alu_op_o = core_pkg::ALU_ADD;
		wb_sel_o = core_pkg::WB_ALU;
		imm_o    = imm_i;
		a_pc_o   = 1'b0;
		b_imm_o  = 1'b0;
		jump_o   = 1'b0;
		jalr_o   = 1'b0;
		branch_o = 1'b0;
		load_o   = 1'b0;
		store_o  = 1'b0;
		rf_we_o  = 1'b0;
		case (opcode)
			core_pkg::OP_LUI:
			begin
				imm_o   = imm_u; // added to x0
				b_imm_o = 1'b1;
				rf_we_o = 1'b1;
			end
			core_pkg::OP_AUIPC:
			begin
				imm_o   = imm_u;
				a_pc_o  = 1'b1;
				b_imm_o = 1'b1;
				rf_we_o = 1'b1;
			end
			core_pkg::OP_JAL:
			begin
				imm_o    = imm_j;
				jump_o   = 1'b1;
				rf_we_o  = 1'b1;
				wb_sel_o = core_pkg::WB_PC4;
			end
			core_pkg::OP_JALR:
			begin
				if (funct3 == 3'b000)
				begin
					jump_o   = 1'b1;
					jalr_o   = 1'b1;
					rf_we_o  = 1'b1;
					wb_sel_o = core_pkg::WB_PC4;
				end
			end
			core_pkg::OP_BRANCH:
			begin
				imm_o    = imm_b;
				branch_o = 1'b1;
				case (funct3)
					3'b000: alu_op_o = core_pkg::ALU_EQ;
					3'b001: alu_op_o = core_pkg::ALU_NE;
					3'b100: alu_op_o = core_pkg::ALU_LT;
					3'b101: alu_op_o = core_pkg::ALU_GE;
					3'b110: alu_op_o = core_pkg::ALU_LTU;
					3'b111: alu_op_o = core_pkg::ALU_GEU;
					default: branch_o = 1'b0;
				endcase
			end
			core_pkg::OP_LOAD:
			begin
				if (funct3 == 3'b010) // lw only
				begin
					b_imm_o  = 1'b1;
					load_o   = 1'b1;
					rf_we_o  = 1'b1;
					wb_sel_o = core_pkg::WB_LOAD;
				end
			end
			core_pkg::OP_STORE:
			begin
				imm_o = imm_s;
				if (funct3 == 3'b010)
				begin
					b_imm_o = 1'b1;
					store_o = 1'b1;
				end
			end
			core_pkg::OP_IMM:
			begin
				b_imm_o = 1'b1;
				rf_we_o = 1'b1;
				case (funct3)
					3'b000: alu_op_o = core_pkg::ALU_ADD;
					3'b010: alu_op_o = core_pkg::ALU_SLT;
					3'b011: alu_op_o = core_pkg::ALU_SLTU;
					3'b100: alu_op_o = core_pkg::ALU_XOR;
					3'b110: alu_op_o = core_pkg::ALU_OR;
					3'b111: alu_op_o = core_pkg::ALU_AND;
					3'b001:
					begin
						if (funct7 == 7'b0000000)
							alu_op_o = core_pkg::ALU_SLL;
						else
							rf_we_o = 1'b0;
					end
					default:
					begin
						if (funct7 == 7'b0000000)
							alu_op_o = core_pkg::ALU_SRL;
						else if (funct7 == 7'b0100000)
							alu_op_o = core_pkg::ALU_SRA;
						else
							rf_we_o = 1'b0;
					end
				endcase
			end
			core_pkg::OP_REG:
			begin
				rf_we_o = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: alu_op_o = core_pkg::ALU_ADD;
					10'b0100000_000: alu_op_o = core_pkg::ALU_SUB;
					10'b0000000_001: alu_op_o = core_pkg::ALU_SLL;
					10'b0000000_010: alu_op_o = core_pkg::ALU_SLT;
					10'b0000000_011: alu_op_o = core_pkg::ALU_SLTU;
					10'b0000000_100: alu_op_o = core_pkg::ALU_XOR;
					10'b0000000_101: alu_op_o = core_pkg::ALU_SRL;
					10'b0100000_101: alu_op_o = core_pkg::ALU_SRA;
					10'b0000000_110: alu_op_o = core_pkg::ALU_OR;
					10'b0000000_111: alu_op_o = core_pkg::ALU_AND;
					default: rf_we_o = 1'b0; // also covers mul/div
				endcase
			end
			default: ; // undefined opcode, leave a bubble
		endcase
	end

endmodule

// File: rtl/core_pkg.sv
package core_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [XLEN-1:0] RESET_VECTOR = 32'h8000_0000;
	localparam logic [31:0]     NOP_INSTR    = 32'h0000_0013; // addi x0, x0, 0

	// major opcodes, instr[6:0]
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;

	// execute operand source
	localparam logic [1:0] FWD_RF  = 2'b00;
	localparam logic [1:0] FWD_WB  = 2'b01;
	localparam logic [1:0] FWD_MEM = 2'b10;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
	} alu_op_t;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_LOAD,
		WB_PC4
	} wb_sel_t;

	typedef struct packed {
		logic [XLEN-1:0]       pc;
		logic [XLEN-1:0]       rs1_val;
		logic [XLEN-1:0]       rs2_val;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       imm;
		alu_op_t               alu_op;
		logic                  a_pc;
		logic                  b_imm;
		logic                  jump;
		logic                  jalr;
		logic                  branch;
		logic                  load;
		logic                  store;
		logic                  rf_we;
		wb_sel_t               wb_sel;
	} id_ex_t;

	typedef struct packed {
		logic [XLEN-1:0]       result;
		logic [XLEN-1:0]       pc4;
		logic [REG_ADDR_W-1:0] rd;
		logic                  rf_we;
		logic                  load;
		wb_sel_t               wb_sel;
	} ex_mem_t;

	typedef struct packed {
		logic [XLEN-1:0]       result;
		logic [XLEN-1:0]       load_data;
		logic [REG_ADDR_W-1:0] rd;
		logic                  rf_we;
		wb_sel_t               wb_sel;
	} mem_wb_t;

endpackage
